// File: run_sim.sh
#!/bin/sh
# build the Wishbone master testbench with Verilator, run it, then search the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_wb_master \
    -f vlog.f -o tb_wb_master_sim || { echo "build failed"; exit 1; }
./obj_dir/tb_wb_master_sim > sim.log 2>&1
cat sim.log
grep -qx '\*\*\* PASSED \*\*\*' sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb_wb_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_master_config.svh"

module tb_wb_master import wb_master_pkg::*; ();

    // expected bus beats are queued in the order the bus has to carry them
    typedef struct packed {
        logic [1:0]            src;
        logic [`WB_ADDR_W-1:0] adr;
        logic                  we;
        logic [`WB_SEL_W-1:0]  sel;
        logic [`WB_DATA_W-1:0] dat;
    } beat_t;

    logic                   i_clk, quick_n_reset, i_wb_ack;
    logic                   i_icache_req, i_icache_qword, o_icache_ready;
    logic                   i_dcache_cached_req, i_dcache_uncached_req, i_dcache_qword;
    logic                   i_dcache_write, o_dcache_cached_ready, o_dcache_uncached_ready;
    logic                   o_wb_we, o_wb_cyc, o_wb_stb;
    logic [`WB_SEL_W-1:0]   i_dcache_byte_enable, o_wb_sel;
    logic [`WB_ADDR_W-1:0]  i_icache_address, i_dcache_address, o_wb_adr;
    logic [`WB_DATA_W-1:0]  i_dcache_write_data, o_icache_read_data, o_dcache_read_data;
    logic [`WB_DATA_W-1:0]  i_wb_dat, o_wb_dat;
    logic [`WB_NUM_SRC-1:0] ready_vec;
    logic [`WB_DATA_W-1:0]  slave_mem [0:255];
    logic [`WB_DATA_W-1:0]  ref_mem [0:255];
    beat_t                  expected [$];
    integer                 seed = 54;
    int                     errors, checks, timeouts, stall, wait_cnt;
    bit                     armed, started;

    wb_master_top wb_master_top_i (.*);

    // ready bits in source index order
    assign ready_vec = {o_icache_ready, o_dcache_uncached_ready, o_dcache_cached_ready};

    initial
    begin
        i_clk = 1'b0;
        forever
            #4 i_clk = ~i_clk;
    end

    // ==================================================
    // reference rules
    // ==================================================

    // every word differs and depends on its whole word index
    function automatic logic [31:0] fill_word(input int idx);
        logic [7:0] a;
        a = idx[7:0];
        fill_word = {a, ~a, a ^ 8'h3c, a + 8'h71};
    endfunction

    // one enabled lane names itself, the upper halfword sits at lane 2, anything else at 0
    function automatic logic [1:0] lane_of(input logic [3:0] be);
        lane_of = 2'd0;
        if ($countones(be) == 1)
        begin
            for (int i = 0; i < 4; i++)
                if (be[i])
                    lane_of = i[1:0];
        end
        else if (be == 4'b1100)
            lane_of = 2'd2;
    endfunction

    // the old word with only the enabled bytes taken from the new data
    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] be);
        merge_bytes = old;
        for (int b = 0; b < 4; b++)
            if (be[b])
                merge_bytes[8*b +: 8] = data[8*b +: 8];
    endfunction

    task automatic report_mismatch(input string what);
        errors++;
        $display("FAILED at %0t: %s", $time, what);
    endtask

    // a line fill wraps the word field inside its line while a single read is one beat
    task automatic add_read_beats(input int src, input bit qword, input logic [31:0] addr);
        beat_t      b;
        logic [31:0] a;
        for (int k = 0; k < (qword ? 4 : 1); k++)
        begin
            a = {addr[31:4], addr[3:2] + k[1:0], 2'b00};
            b = '{src: src[1:0], adr: a, we: 1'b0, sel: 4'hf, dat: ref_mem[a[9:2]]};
            expected.push_back(b);
        end
    endtask

    task automatic add_write_beat(input int src, input logic [31:0] addr, input logic [31:0] data,
                                  input logic [3:0] be);
        beat_t b;
        ref_mem[addr[9:2]] = merge_bytes(ref_mem[addr[9:2]], data, be);
        b = '{src: src[1:0], adr: {addr[31:2], lane_of(be)}, we: 1'b1, sel: be, dat: data};
        expected.push_back(b);
    endtask

    // ==================================================
    // drivers called right after a falling edge
    // ==================================================

    task automatic drive_icache(input bit qword, input logic [31:0] addr);
        i_icache_req     = 1'b1;
        i_icache_qword   = qword;
        i_icache_address = addr;
        started          = 1'b1;
    endtask

    task automatic drive_dcache(input bit uncached, input bit qword, input bit write,
                                input logic [31:0] addr, input logic [31:0] data,
                                input logic [3:0] be);
        i_dcache_cached_req   = !uncached;
        i_dcache_uncached_req = uncached;
        i_dcache_qword        = qword;
        i_dcache_write        = write;
        i_dcache_address      = addr;
        i_dcache_write_data   = data;
        i_dcache_byte_enable  = be;
        started               = 1'b1;
    endtask

    // strobes last exactly one cycle
    task automatic end_strobes;
        @(negedge i_clk);
        i_icache_req          = 1'b0;
        i_dcache_cached_req   = 1'b0;
        i_dcache_uncached_req = 1'b0;
    endtask

    // done once every queued beat was acked and the bus went idle
    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while ((expected.size() != 0 || o_wb_cyc) && n < limit)
        begin
            @(negedge i_clk);
            n++;
        end
        if (expected.size() != 0 || o_wb_cyc)
        begin
            timeouts++;
            $display("timeout at %0t: bus never finished, %0d beats left", $time, expected.size());
            expected.delete();
        end
    endtask

    task automatic run_read(input int src, input bit qword, input logic [31:0] addr);
        @(negedge i_clk);
        add_read_beats(src, qword, addr);
        if (src == SRC_ICACHE)
            drive_icache(qword, addr);
        else
            drive_dcache(src == SRC_DC_UNCACHED, qword, 1'b0, addr, 32'h0, 4'b0101);
        end_strobes();
        wait_drained(200);
    endtask

    // ==================================================
    // slave model and checks
    // ==================================================

    // acks each word after 0 to 3 wait cycles, plus the stall count when a cycle starts
    initial
    begin
        i_wb_ack = 1'b0;
        i_wb_dat = '0;
        armed    = 1'b0;
        for (int i = 0; i < 256; i++)
            slave_mem[i] = fill_word(i);
        forever
        begin
            @(negedge i_clk);
            i_wb_ack = 1'b0;
            i_wb_dat = '0;
            if (quick_n_reset && o_wb_stb)
            begin
                if (!armed)
                begin
                    wait_cnt = stall + ($random(seed) & 3);
                    armed    = 1'b1;
                end
                if (wait_cnt == 0)
                begin
                    i_wb_ack = 1'b1;
                    i_wb_dat = slave_mem[o_wb_adr[9:2]];
                    armed    = 1'b0;
                    if (o_wb_we)
                        slave_mem[o_wb_adr[9:2]] = merge_bytes(i_wb_dat, o_wb_dat, o_wb_sel);
                end
                else
                    wait_cnt--;
            end
        end
    end

    // each acked word is compared with the head of the expected queue
    always @(posedge i_clk)
    begin
        beat_t       b;
        logic [31:0] rdata;
        if (quick_n_reset && o_wb_stb && i_wb_ack)
        begin
            checks++;
            if (expected.size() == 0)
                report_mismatch($sformatf("ack with no beat expected, address %h", o_wb_adr));
            else
            begin
                b     = expected.pop_front();
                rdata = (b.src == 2'(SRC_ICACHE)) ? o_icache_read_data : o_dcache_read_data;
                assert (ready_vec == 3'(1 << b.src))
                    else report_mismatch($sformatf("ready %b, owner %0d", ready_vec, b.src));
                assert (o_wb_adr == b.adr)
                    else report_mismatch($sformatf("address %h, expected %h", o_wb_adr, b.adr));
                assert (o_wb_sel == b.sel && o_wb_we == b.we)
                    else report_mismatch($sformatf("sel %b we %b, expected %b %b",
                                                   o_wb_sel, o_wb_we, b.sel, b.we));
                assert (b.we ? (o_wb_dat == b.dat) : (rdata == b.dat))
                    else report_mismatch($sformatf("data %h, expected %h",
                                                   b.we ? o_wb_dat : rdata, b.dat));
            end
        end
    end

    // nothing moves on the bus between reset and the first strobe
    a_quiet_after_reset : assert property (
        @(posedge i_clk) quick_n_reset && !started |-> !o_wb_cyc && !o_wb_stb && ready_vec == '0
    ) else report_mismatch("bus or ready active before any request");

    // a ready pulse belongs to an acked word and never appears on its own
    a_ready_only_on_ack : assert property (
        @(posedge i_clk) disable iff (!quick_n_reset)
        !(o_wb_stb && i_wb_ack) |-> ready_vec == '0
    ) else report_mismatch("ready pulse without an acked word");

    a_hold_while_stalled : assert property (
        @(posedge i_clk) disable iff (!quick_n_reset)
        o_wb_stb && !i_wb_ack |=> o_wb_stb && $stable(o_wb_adr) && $stable(o_wb_sel) &&
                                  $stable(o_wb_we) && $stable(o_wb_dat)
    ) else report_mismatch("bus outputs changed while stb waited for ack");

    // ==================================================
    // stimulus
    // ==================================================

    initial
    begin
        logic [3:0]  be_list [0:7];
        logic [31:0] addr;
        logic [31:0] data;
        be_list = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b0110, 4'b1111};
        for (int i = 0; i < 256; i++)
            ref_mem[i] = fill_word(i);
        quick_n_reset = 1'b0;
        stall         = 0;
        drive_icache(1'b0, 32'h0);
        drive_dcache(1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 4'h0);
        i_dcache_cached_req = 1'b0;
        i_icache_req        = 1'b0;
        started             = 1'b0;
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        quick_n_reset = 1'b1;
        repeat (3) @(negedge i_clk);
        // single reads whose low address bits must not reach the bus
        run_read(SRC_ICACHE, 1'b0, 32'h0000_0012);
        run_read(SRC_DC_CACHED, 1'b0, 32'h0000_0027);
        run_read(SRC_DC_UNCACHED, 1'b0, 32'h0000_0031);
        // line fills from every start word
        for (int w = 0; w < 4; w++)
        begin
            run_read(SRC_ICACHE, 1'b1, 32'h0000_0040 + 4 * w);
            run_read(SRC_DC_CACHED, 1'b1, 32'h0000_0080 + 4 * w);
        end
        run_read(SRC_DC_UNCACHED, 1'b1, 32'h0000_00c8);
        // writes on alternating ports that are each read back through the cached port
        for (int i = 0; i < 8; i++)
        begin
            addr = 32'h0000_0103 + 8 * i;
            data = 32'hd5c4_b3a2 ^ (32'h0101_0101 * i);
            @(negedge i_clk);
            add_write_beat(i[0] ? SRC_DC_UNCACHED : SRC_DC_CACHED, addr, data, be_list[i]);
            drive_dcache(i[0], 1'b0, 1'b1, addr, data, be_list[i]);
            end_strobes();
            wait_drained(200);
            run_read(SRC_DC_CACHED, 1'b0, addr);
        end
        // a stalled cached read followed by uncached and instruction strobes together
        @(negedge i_clk);
        stall = 10;
        add_read_beats(SRC_DC_CACHED, 1'b0, 32'h0000_0200);
        add_read_beats(SRC_DC_UNCACHED, 1'b0, 32'h0000_0210);
        add_read_beats(SRC_ICACHE, 1'b0, 32'h0000_0220);
        drive_dcache(1'b0, 1'b0, 1'b0, 32'h0000_0200, 32'h0, 4'hf);
        end_strobes();
        @(negedge i_clk);
        drive_dcache(1'b1, 1'b0, 1'b0, 32'h0000_0210, 32'h0, 4'hf);
        drive_icache(1'b0, 32'h0000_0220);
        end_strobes();
        @(posedge i_clk);
        stall = 0;
        wait_drained(300);
        // a stalled instruction fill followed by uncached and cached strobes one cycle apart
        @(negedge i_clk);
        stall = 10;
        add_read_beats(SRC_ICACHE, 1'b1, 32'h0000_0300);
        add_read_beats(SRC_DC_CACHED, 1'b0, 32'h0000_0314);
        add_write_beat(SRC_DC_UNCACHED, 32'h0000_0328, 32'h1122_3344, 4'b0110);
        drive_icache(1'b1, 32'h0000_0300);
        end_strobes();
        drive_dcache(1'b1, 1'b0, 1'b1, 32'h0000_0328, 32'h1122_3344, 4'b0110);
        @(negedge i_clk);
        drive_dcache(1'b0, 1'b0, 1'b0, 32'h0000_0314, 32'h0, 4'hf);
        end_strobes();
        @(posedge i_clk);
        stall = 0;
        wait_drained(300);
        repeat (4) @(negedge i_clk);
        $display("beats checked %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
wb_master_pkg.sv
wb_req_split.sv
wb_req_slot.sv
wb_bus_sequencer.sv
wb_master_top.sv
tb_wb_master.sv

// File: wb_bus_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_master_config.svh"

module wb_bus_sequencer import wb_master_pkg::*;
(
    input  wire logic                   i_clk,
    input  wire logic                   quick_n_reset,
    input  wb_req_t [`WB_NUM_SRC-1:0]   i_pending,
    input  wire logic [`WB_DATA_W-1:0]  i_wb_dat,
    input  wire logic                   i_wb_ack,
    output logic [`WB_NUM_SRC-1:0]      o_done,
    output logic [`WB_NUM_SRC-1:0]      o_ready,
    output logic [`WB_ADDR_W-1:0]       o_wb_adr,
    output logic [`WB_SEL_W-1:0]        o_wb_sel,
    output logic                        o_wb_we,
    output logic [`WB_DATA_W-1:0]       o_wb_dat,
    output logic                        o_wb_cyc,
    output logic                        o_wb_stb
);

    wb_state_e                r_state;

    // one-hot owner of the cycle in progress
    logic [`WB_NUM_SRC-1:0]   r_owner;

    // bus address held in the union so bursts step only the word field
    wb_addr_u                 r_adr;

    logic [`WB_NUM_SRC-1:0]   grant;
    wb_req_t                  pick;
    wb_addr_u                 start_adr;
    logic                     bus_ack;

    // ==================================================
    // fixed priority arbitration
    // ==================================================

    // the scan runs from the highest index down so the lowest pending one wins
    always_comb
    begin
        grant = '0;
        pick  = '0;
        for (int i = `WB_NUM_SRC - 1; i >= 0; i--)
        begin
            if (i_pending[i].valid)
            begin
                grant    = '0;
                grant[i] = 1'b1;
                pick     = i_pending[i];
            end
        end
    end

    // the splitter leaves the byte field clear, the lane offset goes in here
    always_comb
    begin
        start_adr                 = pick.addr;
        start_adr.fields.byte_ofs = pick.lane;
    end

    // ==================================================
    // per-source handshakes
    // ==================================================

    // an ack only counts while a strobe is out on the bus
    assign bus_ack = o_wb_stb && i_wb_ack;

    // every acked word, read or write, is one ready pulse to the owner
    assign o_ready = bus_ack ? r_owner : '0;

    // only the last ack of a cycle releases the owner's slot
    assign o_done = (bus_ack && (r_state == WB_WAIT_ACK)) ? r_owner : '0;

    assign o_wb_adr = r_adr.flat;

    // ==================================================
    // bus state machine
    // ==================================================

    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            r_state  <= WB_IDLE;
            r_owner  <= '0;
            o_wb_cyc <= 1'b0;
            o_wb_stb <= 1'b0;
            o_wb_we  <= 1'b0;
            o_wb_sel <= '0;
        end
        else
        begin
            case (r_state)
                WB_IDLE:
                begin
                    // start the highest priority pending request
                    if (|grant)
                    begin
                        o_wb_cyc <= 1'b1;
                        o_wb_stb <= 1'b1;
                        o_wb_we  <= pick.write;
                        o_wb_sel <= pick.sel;
                        r_owner  <= grant;
                        // a line fill needs three acks before the final one
                        r_state  <= pick.qword ? WB_BURST1 : WB_WAIT_ACK;
                    end
                end

                WB_BURST1:
                begin
                    if (i_wb_ack)
                    begin
                        r_state <= WB_BURST2;
                    end
                end

                WB_BURST2:
                begin
                    if (i_wb_ack)
                    begin
                        r_state <= WB_BURST3;
                    end
                end

                WB_BURST3:
                begin
                    if (i_wb_ack)
                    begin
                        r_state <= WB_WAIT_ACK;
                    end
                end

                WB_WAIT_ACK:
                begin
                    // the final ack closes the cycle, idle holds for at least one clock
                    if (i_wb_ack)
                    begin
                        o_wb_cyc <= 1'b0;
                        o_wb_stb <= 1'b0;
                        o_wb_we  <= 1'b0;
                        r_state  <= WB_IDLE;
                    end
                end

                default:
                begin
                    r_state <= WB_IDLE;
                end
            endcase
        end
    end

    // address and write data are loaded at the start and stepped during a fill
    always_ff @(posedge i_clk)
    begin
        if ((r_state == WB_IDLE) && (|grant))
        begin
            r_adr    <= start_adr;
            o_wb_dat <= pick.wdata;
        end
        else if (i_wb_ack && ((r_state == WB_BURST1) || (r_state == WB_BURST2) ||
                              (r_state == WB_BURST3)))
        begin
            // wrap within the line, the line field never changes
            r_adr.fields.word <= r_adr.fields.word + 1'b1;
        end
    end

    // ==================================================
    // checks
    // ==================================================

    a_burst_steps : assert property (
        @(posedge i_clk) disable iff (!quick_n_reset)
        i_wb_ack && (r_state inside {WB_BURST1, WB_BURST2, WB_BURST3}) |=>
            (r_state == wb_state_e'($past(r_state) + 3'd1))
    ) else $error("burst state did not advance on ack");

    a_wait_ack_ends : assert property (
        @(posedge i_clk) disable iff (!quick_n_reset)
        (r_state == WB_WAIT_ACK) && i_wb_ack |=> (r_state == WB_IDLE) && !o_wb_cyc
    ) else $error("final ack did not return the bus to idle");

    // the slave may stall freely, the master must not move under it
    a_hold_under_stall : assert property (
        @(posedge i_clk) disable iff (!quick_n_reset)
        o_wb_stb && !i_wb_ack |=> o_wb_stb && $stable(o_wb_adr) && $stable(o_wb_sel) &&
                                  $stable(o_wb_we) && $stable(o_wb_dat)
    ) else $error("bus outputs changed while waiting for ack");

    // read data is forwarded unregistered, so an acked read word must be defined
    a_read_data_known : assert property (
        @(posedge i_clk) disable iff (!quick_n_reset)
        bus_ack && !o_wb_we |-> !$isunknown(i_wb_dat)
    ) else $error("slave acked a read with undefined data");

endmodule

`default_nettype wire

// File: wb_master_config.svh
`ifndef WB_MASTER_CONFIG_SVH
`define WB_MASTER_CONFIG_SVH

// ==================================================
// bus geometry shared by the package, RTL and testbench
// ==================================================

// byte address width of the wishbone bus
`define WB_ADDR_W    32

// width of one data word on the bus
`define WB_DATA_W    32

// one select line per byte of the data word
`define WB_SEL_W     4

// number of words fetched by a cache line fill
`define WB_BURST_LEN 4

// request sources are data cached, data uncached and instruction
`define WB_NUM_SRC   3

`endif

// File: wb_master_pkg.sv
`default_nettype none

`include "wb_master_config.svh"

package wb_master_pkg;

    // field widths of an address, derived from the bus geometry
    localparam int WB_WORD_W = $clog2(`WB_BURST_LEN);
    localparam int WB_BYTE_W = $clog2(`WB_SEL_W);
    localparam int WB_LINE_W = `WB_ADDR_W - WB_WORD_W - WB_BYTE_W;

    // source index doubles as priority, the lowest index wins arbitration
    localparam int SRC_DC_CACHED   = 0;
    localparam int SRC_DC_UNCACHED = 1;
    localparam int SRC_ICACHE      = 2;

    // one address word seen either flat or split into line, word and byte
    // the burst logic only ever touches the word field
    typedef union packed {
        logic [`WB_ADDR_W-1:0] flat;
        struct packed {
            logic [WB_LINE_W-1:0] line;
            logic [WB_WORD_W-1:0] word;
            logic [WB_BYTE_W-1:0] byte_ofs;
        } fields;
    } wb_addr_u;

    // a complete memory request as it travels from splitter to sequencer
    typedef struct packed {
        logic                  valid;
        logic                  qword;
        logic                  write;
        wb_addr_u              addr;
        logic [`WB_DATA_W-1:0] wdata;
        logic [`WB_SEL_W-1:0]  sel;
        logic [WB_BYTE_W-1:0]  lane;
    } wb_req_t;

    // bus sequencer states, burst1 to burst3 count the first three acks of a fill
    typedef enum logic [2:0] {
        WB_IDLE     = 3'd0,
        WB_BURST1   = 3'd1,
        WB_BURST2   = 3'd2,
        WB_BURST3   = 3'd3,
        WB_WAIT_ACK = 3'd4
    } wb_state_e;

endpackage

`default_nettype wire

// File: wb_master_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_master_config.svh"

module wb_master_top import wb_master_pkg::*;
(
    input  wire logic                  i_clk,
    input  wire logic                  quick_n_reset,

    // instruction cache side
    input  wire logic                  i_icache_req,
    input  wire logic                  i_icache_qword,
    input  wire logic [`WB_ADDR_W-1:0] i_icache_address,
    output logic [`WB_DATA_W-1:0]      o_icache_read_data,
    output logic                       o_icache_ready,

    // data cache side, the two ports share address, data and enables
    input  wire logic                  i_dcache_cached_req,
    input  wire logic                  i_dcache_uncached_req,
    input  wire logic                  i_dcache_qword,
    input  wire logic                  i_dcache_write,
    input  wire logic [`WB_DATA_W-1:0] i_dcache_write_data,
    input  wire logic [`WB_SEL_W-1:0]  i_dcache_byte_enable,
    input  wire logic [`WB_ADDR_W-1:0] i_dcache_address,
    output logic [`WB_DATA_W-1:0]      o_dcache_read_data,
    output logic                       o_dcache_cached_ready,
    output logic                       o_dcache_uncached_ready,

    // wishbone classic master port
    output logic [`WB_ADDR_W-1:0]      o_wb_adr,
    output logic [`WB_SEL_W-1:0]       o_wb_sel,
    output logic                       o_wb_we,
    input  wire logic [`WB_DATA_W-1:0] i_wb_dat,
    output logic [`WB_DATA_W-1:0]      o_wb_dat,
    output logic                       o_wb_cyc,
    output logic                       o_wb_stb,
    input  wire logic                  i_wb_ack
);

    wb_req_t [`WB_NUM_SRC-1:0] split_req;
    wb_req_t [`WB_NUM_SRC-1:0] pending;
    logic [`WB_NUM_SRC-1:0]    done;
    logic [`WB_NUM_SRC-1:0]    ready;

    wb_req_split wb_req_split_i (
        .i_icache_req          (i_icache_req),
        .i_icache_qword        (i_icache_qword),
        .i_icache_address      (i_icache_address),
        .i_dcache_cached_req   (i_dcache_cached_req),
        .i_dcache_uncached_req (i_dcache_uncached_req),
        .i_dcache_qword        (i_dcache_qword),
        .i_dcache_write        (i_dcache_write),
        .i_dcache_write_data   (i_dcache_write_data),
        .i_dcache_byte_enable  (i_dcache_byte_enable),
        .i_dcache_address      (i_dcache_address),
        .o_req                 (split_req)
    );

    // one slot per source holds its strobe until the bus cycle is done
    for (genvar g = 0; g < `WB_NUM_SRC; g++)
    begin : g_slot
        wb_req_slot wb_req_slot_i (
            .i_clk         (i_clk),
            .quick_n_reset (quick_n_reset),
            .i_req         (split_req[g]),
            .i_done        (done[g]),
            .o_pending     (pending[g])
        );
    end

    wb_bus_sequencer wb_bus_sequencer_i (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .i_pending     (pending),
        .i_wb_dat      (i_wb_dat),
        .i_wb_ack      (i_wb_ack),
        .o_done        (done),
        .o_ready       (ready),
        .o_wb_adr      (o_wb_adr),
        .o_wb_sel      (o_wb_sel),
        .o_wb_we       (o_wb_we),
        .o_wb_dat      (o_wb_dat),
        .o_wb_cyc      (o_wb_cyc),
        .o_wb_stb      (o_wb_stb)
    );

    // ready bits map back to the named per-source outputs
    assign o_dcache_cached_ready   = ready[SRC_DC_CACHED];
    assign o_dcache_uncached_ready = ready[SRC_DC_UNCACHED];
    assign o_icache_ready          = ready[SRC_ICACHE];

    // read data is valid in the ready cycle and goes straight through
    assign o_icache_read_data      = i_wb_dat;
    assign o_dcache_read_data      = i_wb_dat;

endmodule

`default_nettype wire

// File: wb_req_slot.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_master_config.svh"

module wb_req_slot import wb_master_pkg::*;
(
    input  wire logic    i_clk,
    input  wire logic    quick_n_reset,
    input  wb_req_t      i_req,
    input  wire logic    i_done,
    output wb_req_t      o_pending
);

    // ==================================================
    // pending flag and stored request
    // ==================================================

    // high from the edge after the strobe until the edge that samples done
    logic    r_pending;

    // captured request fields, meaningful only while r_pending is set
    wb_req_t r_req;

    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            r_pending <= 1'b0;
        end
        else if (i_req.valid)
        begin
            r_pending <= 1'b1;
        end
        else if (i_done)
        begin
            r_pending <= 1'b0;
        end
    end

    // the strobe is a single cycle, so the fields are latched right then
    always_ff @(posedge i_clk)
    begin
        if (i_req.valid)
        begin
            r_req <= i_req;
        end
    end

    // the sequencer sees the stored fields with valid meaning pending
    always_comb
    begin
        o_pending       = r_req;
        o_pending.valid = r_pending;
    end

    // ==================================================
    // protocol checks
    // ==================================================

    // a requester waits for its last ready before issuing the next strobe
    a_no_strobe_while_pending : assert property (
        @(posedge i_clk) disable iff (!quick_n_reset)
        i_req.valid |-> !r_pending
    ) else $error("strobe arrived while the slot was still pending");

    // the sequencer only completes a cycle it started from this slot
    a_done_only_when_pending : assert property (
        @(posedge i_clk) disable iff (!quick_n_reset)
        i_done |-> r_pending
    ) else $error("done pulse for a slot with nothing pending");

endmodule

`default_nettype wire

// File: wb_req_split.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_master_config.svh"

module wb_req_split import wb_master_pkg::*;
(
    input  wire logic                  i_icache_req,
    input  wire logic                  i_icache_qword,
    input  wire logic [`WB_ADDR_W-1:0] i_icache_address,
    input  wire logic                  i_dcache_cached_req,
    input  wire logic                  i_dcache_uncached_req,
    input  wire logic                  i_dcache_qword,
    input  wire logic                  i_dcache_write,
    input  wire logic [`WB_DATA_W-1:0] i_dcache_write_data,
    input  wire logic [`WB_SEL_W-1:0]  i_dcache_byte_enable,
    input  wire logic [`WB_ADDR_W-1:0] i_dcache_address,
    output wb_req_t [`WB_NUM_SRC-1:0]  o_req
);

    // byte lane offset for the low address bits
    // a single lane gives its own index, the upper halfword gives 2, all else 0
    function automatic logic [WB_BYTE_W-1:0] lane_from_sel(input logic [`WB_SEL_W-1:0] be);
        case (be)
            4'b0001: lane_from_sel = 2'd0;
            4'b0010: lane_from_sel = 2'd1;
            4'b0100: lane_from_sel = 2'd2;
            4'b1000: lane_from_sel = 2'd3;
            4'b1100: lane_from_sel = 2'd2;
            default: lane_from_sel = 2'd0;
        endcase
    endfunction

    logic [`WB_SEL_W-1:0] dc_sel;
    wb_req_t              dc_req;

    // reads always fetch the whole word, only writes narrow the lanes
    assign dc_sel = i_dcache_write ? i_dcache_byte_enable : {`WB_SEL_W{1'b1}};

    // both data ports share one set of request fields
    always_comb
    begin
        dc_req                        = '0;
        dc_req.qword                  = i_dcache_qword && !i_dcache_write;
        dc_req.write                  = i_dcache_write;
        dc_req.addr.flat              = i_dcache_address;
        dc_req.addr.fields.byte_ofs   = '0;
        dc_req.wdata                  = i_dcache_write_data;
        dc_req.sel                    = dc_sel;
        dc_req.lane                   = lane_from_sel(dc_sel);
    end

    always_comb
    begin
        o_req                        = '0;
        o_req[SRC_DC_CACHED]         = dc_req;
        o_req[SRC_DC_CACHED].valid   = i_dcache_cached_req;
        o_req[SRC_DC_UNCACHED]       = dc_req;
        o_req[SRC_DC_UNCACHED].valid = i_dcache_uncached_req;
        // instruction fetches are word aligned reads over all lanes
        o_req[SRC_ICACHE].valid      = i_icache_req;
        o_req[SRC_ICACHE].qword      = i_icache_qword;
        o_req[SRC_ICACHE].addr.flat  = {i_icache_address[`WB_ADDR_W-1:WB_BYTE_W], 2'b00};
        o_req[SRC_ICACHE].sel        = {`WB_SEL_W{1'b1}};
    end

    // the data cache drives one shared field set, so only one port may strobe
    always_comb
    begin
        assert (!(i_dcache_cached_req && i_dcache_uncached_req))
            else $error("data cached and uncached strobes in the same cycle");
    end

endmodule

`default_nettype wire
